// File: Bender.yml
package:
  name: icache

sources:
  - include_dirs:
      - hw
    files:
      - hw/icache_addr_pkg.sv
      - hw/icache_ctrl_pkg.sv
      - hw/icache_tag_array.sv
      - hw/icache_data_array.sv
      - hw/icache_ctrl.sv
      - hw/icache_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/icache_mem_model.sv
      - testbench/icache_tb.sv

// File: compile.f
+incdir+hw
hw/icache_addr_pkg.sv
hw/icache_ctrl_pkg.sv
hw/icache_tag_array.sv
hw/icache_data_array.sv
hw/icache_ctrl.sv
hw/icache_top.sv
testbench/icache_mem_model.sv
testbench/icache_tb.sv

// File: hw/icache_addr_pkg.sv
`include "icache_consts.svh"

// how a fetch address is carved up
package icache_addr_pkg;

  // full fetch address as seen by the cpu and the bus
  typedef logic [`ICACHE_XLEN-1:0] addr_t;

  // upper address bits kept per line
  // compared against the stored tag on lookup
  typedef logic [`ICACHE_TAG_W-1:0] tag_t;

  // selects one of the 128 lines
  typedef logic [`ICACHE_IDX_W-1:0] index_t;

  // selects one of the 16 words inside a line
  // byte offset bits [1:0] are dropped, fetch is word aligned
  typedef logic [`ICACHE_WSEL_W-1:0] word_sel_t;

endpackage

// File: hw/icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// cache geometry: 8 KB direct mapped
// 128 lines of 64 bytes each

// address and data bus width
`define ICACHE_XLEN 32

// address split: tag | index | byte offset
`define ICACHE_TAG_W 19
`define ICACHE_IDX_W 7
`define ICACHE_OFS_W 6

// word select inside a line, offset minus the byte-in-word bits
`define ICACHE_WSEL_W 4

// one refill beat per word, no burst on wishbone classic
`define ICACHE_LINE_WORDS 16

// top address bit marks peripheral space, never cached
`define ICACHE_UNCACHE_BIT 31

`endif

// File: hw/icache_ctrl.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_ctrl
  import icache_addr_pkg::*;
  import icache_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  // cpu side
  input  logic      req_valid_i,
  input  addr_t     req_addr_i,
  output word_t     rdata_o,
  output logic      rdata_valid_o,
  // tag array
  input  logic      hit_i,
  output tag_t      tag_o,
  output index_t    index_o,
  output logic      tag_write_o,
  // data array
  output word_sel_t word_sel_o,
  output logic      data_write_o,
  output word_t     data_wdata_o,
  input  word_t     data_rdata_i,
  // wishbone classic master, read only
  output logic      wb_cyc_o,
  output logic      wb_stb_o,
  output logic      wb_we_o,
  output addr_t     wb_adr_o,
  input  word_t     wb_dat_i,
  input  logic      wb_ack_i
);

  icache_state_t state_q;

  // fetch address captured in IDLE
  addr_t addr_q;

  // word returned by a bypass read
  word_t unc_data_q;

  // refill progress
  beat_cnt_t beat_cnt_q;

  // high for the one cycle after the last refill ack
  logic tag_write_q;

  logic uncached;
  logic bus_ack;
  logic last_beat;

  // peripheral space skips the arrays
  assign uncached = addr_q[`ICACHE_UNCACHE_BIT];

  // beat completes only while the strobe is ours
  assign bus_ack = wb_stb_o & wb_ack_i;

  assign last_beat = (beat_cnt_q == beat_cnt_t'(`ICACHE_LINE_WORDS - 1));

  // lookup fields straight off the registered address
  assign tag_o   = addr_q[`ICACHE_XLEN-1 -: `ICACHE_TAG_W];
  assign index_o = addr_q[`ICACHE_OFS_W +: `ICACHE_IDX_W];

  // refill walks the line by beat, otherwise the requested word
  assign word_sel_o = (state_q == REFILL) ? beat_cnt_q
                    : addr_q[`ICACHE_OFS_W-`ICACHE_WSEL_W +: `ICACHE_WSEL_W];

  assign tag_write_o = tag_write_q;

  // every refill ack lands in the array
  assign data_write_o = (state_q == REFILL) & bus_ack;
  assign data_wdata_o = wb_dat_i;

  // address still held while rdata_valid_o pulses
  assign rdata_o = uncached ? unc_data_q : data_rdata_i;

  // instruction side never writes
  assign wb_we_o = 1'b0;

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q       <= RESET;
      rdata_valid_o <= 1'b0;
      wb_cyc_o      <= 1'b0;
      wb_stb_o      <= 1'b0;
      beat_cnt_q    <= '0;
      tag_write_q   <= 1'b0;
    end else begin
      // single cycle pulse
      rdata_valid_o <= 1'b0;
      case (state_q)
        RESET: begin
          state_q <= IDLE;
        end
        IDLE: begin
          // requests are only taken here
          if (req_valid_i) begin
            state_q <= LOOKUP;
          end
        end
        LOOKUP: begin
          if (uncached) begin
            // single word bypass read
            state_q  <= UNCACHED;
            wb_cyc_o <= 1'b1;
            wb_stb_o <= 1'b1;
          end else if (hit_i) begin
            rdata_valid_o <= 1'b1;
            state_q       <= IDLE;
          end else begin
            // miss, fetch the whole line
            state_q    <= REFILL;
            wb_cyc_o   <= 1'b1;
            wb_stb_o   <= 1'b1;
            beat_cnt_q <= '0;
          end
        end
        REFILL: begin
          if (tag_write_q) begin
            // tag lands this edge, retry the lookup
            tag_write_q <= 1'b0;
            state_q     <= LOOKUP;
          end else if (bus_ack) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
            if (last_beat) begin
              // 16th ack closes the cycle
              wb_cyc_o    <= 1'b0;
              wb_stb_o    <= 1'b0;
              tag_write_q <= 1'b1;
            end
          end
        end
        UNCACHED: begin
          if (bus_ack) begin
            wb_cyc_o      <= 1'b0;
            wb_stb_o      <= 1'b0;
            rdata_valid_o <= 1'b1;
            state_q       <= IDLE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // address and data registers
  always_ff @(posedge clk) begin
    if (state_q == IDLE && req_valid_i) begin
      addr_q <= req_addr_i;
    end
    // bus address set up with the strobe, held through wait states
    if (state_q == LOOKUP) begin
      if (uncached) begin
        wb_adr_o <= addr_q;
      end else begin
        // line aligned start of refill
        wb_adr_o <= {addr_q[`ICACHE_XLEN-1:`ICACHE_OFS_W], {`ICACHE_OFS_W{1'b0}}};
      end
    end else if (bus_ack) begin
      // next word of the line
      wb_adr_o <= wb_adr_o + addr_t'(4);
    end
    if (state_q == UNCACHED && bus_ack) begin
      unc_data_q <= wb_dat_i;
    end
  end

endmodule

// File: hw/icache_ctrl_pkg.sv
`include "icache_consts.svh"

// data words and controller state
package icache_ctrl_pkg;

  // instruction word, same width as the bus data
  typedef logic [`ICACHE_XLEN-1:0] word_t;

  // counts refill beats 0..15, wraps after the last one
  typedef logic [`ICACHE_WSEL_W-1:0] beat_cnt_t;

  // controller states
  typedef enum logic [2:0] {
    RESET,
    IDLE,
    LOOKUP,
    REFILL,
    UNCACHED
  } icache_state_t;

endpackage

// File: hw/icache_data_array.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_data_array
  import icache_addr_pkg::*;
  import icache_ctrl_pkg::*;
(
  input  logic      clk,
  input  index_t    index_i,
  input  word_sel_t word_sel_i,
  input  logic      write_i,
  input  word_t     wdata_i,
  output word_t     rdata_o
);

  localparam int unsigned LINES = 1 << `ICACHE_IDX_W;

  // 128 lines x 16 words
  // contents only mean something once the tag array says valid
  word_t mem [LINES][`ICACHE_LINE_WORDS];

  // one word per edge
  // refill fills the line in beat order
  always_ff @(posedge clk) begin
    if (write_i) begin
      mem[index_i][word_sel_i] <= wdata_i;
    end
  end

  // async read
  // word select follows the fetch address outside refill
  assign rdata_o = mem[index_i][word_sel_i];

endmodule

// File: hw/icache_tag_array.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_tag_array
  import icache_addr_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  index_t index_i,
  input  tag_t   tag_i,
  input  logic   write_i,
  output logic   hit_o
);

  localparam int unsigned LINES = 1 << `ICACHE_IDX_W;

  // one valid flag per line
  logic [LINES-1:0] valid_q;

  // stored tag per line
  tag_t tag_mem [LINES];

  // valid flags cleared on reset so every line starts empty
  // a write marks the refilled line usable
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (write_i) begin
      valid_q[index_i] <= 1'b1;
    end
  end

  // tag storage
  // written together with the valid flag after the last refill beat
  always_ff @(posedge clk) begin
    if (write_i) begin
      tag_mem[index_i] <= tag_i;
    end
  end

  // combinational compare on the registered lookup address
  // stale tags are masked by the valid flag
  assign hit_o = valid_q[index_i] && (tag_mem[index_i] == tag_i);

endmodule

// File: hw/icache_top.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_top
  import icache_addr_pkg::*;
  import icache_ctrl_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  // cpu side
  input  logic  req_valid_i,
  input  addr_t req_addr_i,
  output word_t rdata_o,
  output logic  rdata_valid_o,
  // wishbone classic master
  output logic  wb_cyc_o,
  output logic  wb_stb_o,
  output logic  wb_we_o,
  output addr_t wb_adr_o,
  input  word_t wb_dat_i,
  input  logic  wb_ack_i
);

  // tag array hookup
  logic      hit;
  tag_t      tag;
  index_t    index;
  logic      tag_write;

  // data array hookup, shares the line index
  word_sel_t word_sel;
  logic      data_write;
  word_t     data_wdata;
  word_t     data_rdata;

  icache_ctrl icache_ctrl_inst (
    .clk           (clk),
    .rst           (rst),
    .req_valid_i   (req_valid_i),
    .req_addr_i    (req_addr_i),
    .rdata_o       (rdata_o),
    .rdata_valid_o (rdata_valid_o),
    .hit_i         (hit),
    .tag_o         (tag),
    .index_o       (index),
    .tag_write_o   (tag_write),
    .word_sel_o    (word_sel),
    .data_write_o  (data_write),
    .data_wdata_o  (data_wdata),
    .data_rdata_i  (data_rdata),
    .wb_cyc_o      (wb_cyc_o),
    .wb_stb_o      (wb_stb_o),
    .wb_we_o       (wb_we_o),
    .wb_adr_o      (wb_adr_o),
    .wb_dat_i      (wb_dat_i),
    .wb_ack_i      (wb_ack_i)
  );

  icache_tag_array icache_tag_array_inst (
    .clk     (clk),
    .rst     (rst),
    .index_i (index),
    .tag_i   (tag),
    .write_i (tag_write),
    .hit_o   (hit)
  );

  icache_data_array icache_data_array_inst (
    .clk        (clk),
    .index_i    (index),
    .word_sel_i (word_sel),
    .write_i    (data_write),
    .wdata_i    (data_wdata),
    .rdata_o    (data_rdata)
  );

endmodule

// File: testbench/icache_mem_model.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_mem_model
  import icache_addr_pkg::*;
  import icache_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  // read only wishbone classic slave
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  addr_t       wb_adr_i,
  output word_t       wb_dat_o,
  output logic        wb_ack_o,
  // bus statistics for the checks
  output logic [31:0] ack_count_o,
  output addr_t       first_adr_o,
  output logic [31:0] step_err_o
);

  // wait state source
  logic [31:0] lfsr_q;
  logic [31:0] lfsr_a;
  logic [31:0] lfsr_b;

  // wait states drawn for a new beat
  logic [1:0] draw;

  // remaining wait states of the current beat
  logic [1:0] wait_q;
  logic       busy_q;

  // at least one beat already acked in this bus cycle
  logic       in_cycle_q;
  addr_t      prev_adr_q;

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // memory word is the address with its upper half inverted
  function automatic word_t mem_word(input addr_t a);
    mem_word = {~a[31:16], a[15:0]};
  endfunction

  // two steps for the two wait state bits
  assign lfsr_a = lfsr_step(lfsr_q);
  assign lfsr_b = lfsr_step(lfsr_a);
  assign draw   = {lfsr_a[0], lfsr_b[0]};

  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr_q      <= 32'h6bec65d7;
      wait_q      <= '0;
      busy_q      <= 1'b0;
      in_cycle_q  <= 1'b0;
      prev_adr_q  <= '0;
      wb_dat_o    <= '0;
      wb_ack_o    <= 1'b0;
      ack_count_o <= '0;
      first_adr_o <= '0;
      step_err_o  <= '0;
    end else begin
      // ack lasts one cycle
      wb_ack_o <= 1'b0;
      if (!wb_cyc_i) begin
        in_cycle_q <= 1'b0;
      end
      // no new beat while the previous ack is still out
      if (wb_cyc_i && wb_stb_i && !wb_we_i && !wb_ack_o) begin
        // every new beat consumes one draw
        if (!busy_q) begin
          lfsr_q <= lfsr_b;
        end
        if (!busy_q && draw != 2'd0) begin
          // new beat waits 1..3 cycles
          busy_q <= 1'b1;
          wait_q <= draw - 2'd1;
        end else if (busy_q && wait_q != 2'd0) begin
          wait_q <= wait_q - 2'd1;
        end else begin
          busy_q      <= 1'b0;
          wb_ack_o    <= 1'b1;
          wb_dat_o    <= mem_word(wb_adr_i);
          ack_count_o <= ack_count_o + 32'd1;
          if (!in_cycle_q) begin
            first_adr_o <= wb_adr_i;
          end else if (wb_adr_i != prev_adr_q + addr_t'(4)) begin
            // later beats must walk the line word by word
            step_err_o <= step_err_o + 32'd1;
          end
          in_cycle_q <= 1'b1;
          prev_adr_q <= wb_adr_i;
        end
      end
    end
  end

endmodule

// File: testbench/icache_tb.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_tb
  import icache_addr_pkg::*;
  import icache_ctrl_pkg::*;
();

  localparam int N_STIM       = 16;
  localparam int RESET_CYCLES = 8;
  // worst case refill is 16 beats of up to 5 cycles each
  localparam int TIMEOUT_CYCLES =
    N_STIM * (`ICACHE_LINE_WORDS * 5 + 10) + RESET_CYCLES + 10;

  // one request: address, bus reads it should cost, first bus address
  typedef struct packed {
    addr_t      addr;
    logic [4:0] reads;
    addr_t      first;
  } stim_t;

  stim_t stim [N_STIM];

  logic        clk;
  logic        rst;
  logic        req_valid;
  addr_t       req_addr;
  word_t       rdata;
  logic        rdata_valid;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  addr_t       wb_adr;
  word_t       wb_dat;
  logic        wb_ack;
  logic [31:0] ack_count;
  addr_t       first_adr;
  logic [31:0] step_err;

  int err_cnt;

  icache_top icache_top_inst (
    .clk           (clk),
    .rst           (rst),
    .req_valid_i   (req_valid),
    .req_addr_i    (req_addr),
    .rdata_o       (rdata),
    .rdata_valid_o (rdata_valid),
    .wb_cyc_o      (wb_cyc),
    .wb_stb_o      (wb_stb),
    .wb_we_o       (wb_we),
    .wb_adr_o      (wb_adr),
    .wb_dat_i      (wb_dat),
    .wb_ack_i      (wb_ack)
  );

  icache_mem_model icache_mem_model_inst (
    .clk         (clk),
    .rst         (rst),
    .wb_cyc_i    (wb_cyc),
    .wb_stb_i    (wb_stb),
    .wb_we_i     (wb_we),
    .wb_adr_i    (wb_adr),
    .wb_dat_o    (wb_dat),
    .wb_ack_o    (wb_ack),
    .ack_count_o (ack_count),
    .first_adr_o (first_adr),
    .step_err_o  (step_err)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // word stored at any address, upper half inverted
  function automatic word_t expected_word(input addr_t a);
    expected_word = {~a[31:16], a[15:0]};
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    err_cnt++;
    $display("Error at %0t: %s expected %h got %h", $time, name, exp, act);
  endtask

  // no response and no bus activity
  task automatic check_bus_quiet();
    if (rdata_valid !== 1'b0) report_mismatch("rdata_valid_o", 32'd0, rdata_valid);
    if (wb_cyc !== 1'b0) report_mismatch("wb_cyc_o", 32'd0, wb_cyc);
    if (wb_stb !== 1'b0) report_mismatch("wb_stb_o", 32'd0, wb_stb);
  endtask

  // index 0x41 is shared by 0x1040 and 0x3040, tags differ in bit 13
  task automatic fill_table();
    stim[0]  = {32'h0000_1040, 5'd16, 32'h0000_1040};  // cold miss
    stim[1]  = {32'h0000_1044, 5'd0,  32'h0};          // same line
    stim[2]  = {32'h0000_107c, 5'd0,  32'h0};          // last word of line
    stim[3]  = {32'h0000_1040, 5'd0,  32'h0};
    stim[4]  = {32'h8000_0010, 5'd1,  32'h8000_0010};  // peripheral space
    stim[5]  = {32'h8000_0010, 5'd1,  32'h8000_0010};  // not cached, reads again
    stim[6]  = {32'h0000_3048, 5'd16, 32'h0000_3040};  // evicts 0x1040
    stim[7]  = {32'h0000_3040, 5'd0,  32'h0};
    stim[8]  = {32'h0000_1050, 5'd16, 32'h0000_1040};  // evicted, refill again
    stim[9]  = {32'h0000_3048, 5'd16, 32'h0000_3040};
    stim[10] = {32'h0001_2f00, 5'd16, 32'h0001_2f00};
    stim[11] = {32'h0001_2f3c, 5'd0,  32'h0};
    stim[12] = {32'h8000_1234, 5'd1,  32'h8000_1234};
    stim[13] = {32'h0000_3070, 5'd0,  32'h0};
    stim[14] = {32'h7fff_ffc8, 5'd16, 32'h7fff_ffc0};  // highest cached line
    stim[15] = {32'h7fff_fffc, 5'd0,  32'h0};
  endtask

  // one request in flight, wait for the answer, then check it
  task automatic run_request(input stim_t s);
    logic [31:0] acks_before;
    logic [31:0] steps_before;
    logic [31:0] reads;
    int          cycles;
    @(posedge clk);
    acks_before  = ack_count;
    steps_before = step_err;
    req_valid <= 1'b1;
    req_addr  <= s.addr;
    // the cache samples the request at this edge
    @(posedge clk);
    req_valid <= 1'b0;
    cycles = 0;
    while (rdata_valid !== 1'b1) begin
      @(posedge clk);
      cycles++;
    end
    reads = ack_count - acks_before;
    if (rdata !== expected_word(s.addr)) begin
      report_mismatch("rdata_o", expected_word(s.addr), rdata);
    end
    if (reads !== 32'(s.reads)) report_mismatch("bus reads", 32'(s.reads), reads);
    if (s.reads != 0 && first_adr !== s.first) begin
      report_mismatch("first wb_adr_o", s.first, first_adr);
    end
    if (step_err != steps_before) begin
      err_cnt++;
      $display("at %0t the bus address did not advance by 4 within a refill for %h",
               $time, s.addr);
    end
    // hits answer two edges after sampling
    if (s.reads == 0 && cycles != 2) report_mismatch("hit latency", 32'd2, cycles);
    if (wb_cyc !== 1'b0) report_mismatch("wb_cyc_o", 32'd0, wb_cyc);
    if (wb_we !== 1'b0) report_mismatch("wb_we_o", 32'd0, wb_we);
    // single cycle pulse
    @(posedge clk);
    if (rdata_valid !== 1'b0) report_mismatch("rdata_valid_o", 32'd0, rdata_valid);
  endtask

  initial begin : main
    int i;
    err_cnt   = 0;
    rst       = 1'b1;
    req_valid = 1'b0;
    req_addr  = '0;
    fill_table();
    // first edge applies the reset
    @(posedge clk);
    for (i = 1; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      check_bus_quiet();
    end
    rst <= 1'b0;
    repeat (2) begin
      @(posedge clk);
      check_bus_quiet();
    end
    for (i = 0; i < N_STIM; i++) begin
      run_request(stim[i]);
    end
    $display("%0d requests, %0d bus reads, %0d errors", N_STIM, ack_count, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // run limit
  initial begin : watchdog
    int cycle_cnt;
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, the cache never answered", cycle_cnt);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
